/* verification/mvm_vectors.txt */
// per case: len (0 = 128), n, eight rows of n words, n vector words, then
// eight expected results when n covers the run; ffffffff ends the list.
00000000 00000000                           // full depth, all random
00000001 00000001                           // len 1
00000001 00000002 00000003 00000004 00000005 00000006 00000007 00000008
00000003
00000003 00000006 00000009 0000000c 0000000f 00000012 00000015 00000018
00000005 00000005                           // len 5
00000001 00000002 00000003 00000004 00000005 00000002 00000004 00000006 00000008 0000000a
00000003 00000006 00000009 0000000c 0000000f 00000004 00000008 0000000c 00000010 00000014
00000005 0000000a 0000000f 00000014 00000019 00000006 0000000c 00000012 00000018 0000001e
00000007 0000000e 00000015 0000001c 00000023 00000008 00000010 00000018 00000020 00000028
00000001 00000001 00000002 00000002 00000003
00000020 00000040 00000060 00000080 000000a0 000000c0 000000e0 00000100
00000002 00000002                           // len 2, products wrap
ffffffff 80000000 fffffffe 80000001 fffffffd 80000002 fffffffc 80000003
fffffffb 80000004 fffffffa 80000005 fffffff9 80000006 fffffff8 80000007
ffffffff 00000002
00000001 00000004 00000007 0000000a 0000000d 00000010 00000013 00000016
ffffffff

/* compile.f */
+incdir+src
src/mvm_data_pkg.sv
src/mvm_cfg_pkg.sv
src/mvm_core.sv
src/mvm_regs.sv
src/mvm_sequencer.sv
src/mvm_top.sv
verification/tb_mvm.sv

/* Makefile */
SIM      := verilator
TOP      := tb_mvm
FILELIST := compile.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_mvm.sv */
`timescale 1ns/100ps
`include "mvm_macros.svh"

module tb_mvm;
    import mvm_data_pkg::*;
    import mvm_cfg_pkg::*;

    localparam int      CLK_PERIOD = 20;
    localparam int      NC         = `MVM_NUM_CORES;
    localparam int      DEPTH      = `MVM_MAT_DEPTH;
    localparam int      FILE_WORDS = 256;
    localparam int      LIMIT      = 200;  // polls or cycles allowed per wait.
    localparam status_t ST_BUSY    = '{busy: 1'b1, done: 1'b0};
    localparam status_t ST_DONE    = '{busy: 1'b0, done: 1'b1};

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [7:0] paddr;
    data_t      pwdata;
    data_t      prdata;
    logic       pready;
    logic       pslverr;
    data_t      words [FILE_WORDS];
    data_t      mat_m [NC][DEPTH];  // reference copy of every core row.
    data_t      vec_m [DEPTH];
    integer     seed;

    mvm_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED at %0d ns: %s = %h, expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic check_status(input string name, input status_t got, input status_t exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED at %0d ns: %s = %b, expected %b",
                                      $time, name, got, exp));
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_error($sformatf("FAILED at %0d ns: %s = %b, expected %b",
                                      $time, name, got, exp));
    endtask

    // setup and access phases both start on a falling edge.
    task automatic apb_access(input logic wr, input logic [7:0] addr, input data_t wdata,
                              input logic exp_err, output data_t rdata);
        int cycles;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 0;
        #(CLK_PERIOD / 4);  // responses settle well before the rising edge.
        while (pready !== 1'b1) begin
            if (cycles == LIMIT)
                stop_with_error("timeout waiting for pready");
            @(negedge clk);
            #(CLK_PERIOD / 4);
            cycles++;
        end
        check_err($sformatf("pslverr at offset %h", addr), pslverr, exp_err);
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic load_pair(input int c, input int k);
        data_t rd;
        apb_access(1'b1, REG_MAT_SEL, data_t'((c << 8) | k), 1'b0, rd);
        apb_access(1'b1, REG_MAT_LO, mat_m[c][k], 1'b0, rd);
        apb_access(1'b1, REG_MAT_HI, mat_m[c][k + 1], 1'b0, rd);
    endtask

    task automatic load_all();
        data_t rd;
        for (int c = 0; c < NC; c++)
            for (int k = 0; k < DEPTH; k += 2)
                load_pair(c, k);
        apb_access(1'b1, REG_VEC_ADDR, '0, 1'b0, rd);
        for (int k = 0; k < DEPTH; k++)
            apb_access(1'b1, REG_VEC_DATA, vec_m[k], 1'b0, rd);  // address auto-increments.
    endtask

    // row word times vector word, summed over k below n, low 32 bits kept.
    function automatic data_t model_result(input int c, input int n);
        data_t sum;
        sum = '0;
        for (int k = 0; k < n; k++)
            sum += mat_m[c][k] * vec_m[k];
        return sum;
    endfunction

    task automatic run_job(input data_t len_w, input bit inject_errors, input int n);
        data_t   rd;
        status_t st;
        int      polls;
        apb_access(1'b1, REG_LEN, len_w, 1'b0, rd);
        apb_access(1'b1, REG_CTRL, 32'h1, 1'b0, rd);
        apb_access(1'b0, REG_STATUS, '0, 1'b0, rd);
        check_status("status after start", status_t'(rd[1:0]), ST_BUSY);
        if (inject_errors) begin
            apb_access(1'b1, REG_LEN, 32'h3, 1'b1, rd);
            apb_access(1'b0, 8'h40, '0, 1'b1, rd);
            apb_access(1'b0, REG_RESULT, '0, 1'b1, rd);
            check_data("prdata on error", rd, '0);
        end
        polls = 0;
        st    = '0;
        while (!st.done) begin
            if (polls == LIMIT)
                stop_with_error("timeout waiting for done after start");
            apb_access(1'b0, REG_STATUS, '0, 1'b0, rd);
            st = status_t'(rd[1:0]);
            polls++;
        end
        check_status("status at end of run", st, ST_DONE);
        for (int c = 0; c < NC; c++) begin
            apb_access(1'b0, 8'(REG_RESULT + 4 * c), '0, 1'b0, rd);
            check_data($sformatf("result[%0d]", c), rd, model_result(c, n));
        end
    endtask

    task automatic run_file_cases();
        int    pos;
        int    n;
        int    eff;
        data_t len_w;
        pos = 0;
        while (pos < FILE_WORDS - 1 && words[pos] !== 32'hFFFF_FFFF) begin
            len_w = words[pos];
            n     = int'(words[pos + 1]);
            eff   = (len_w == 0) ? DEPTH : int'(len_w);
            pos  += 2;
            for (int c = 0; c < NC; c++)
                for (int k = 0; k < DEPTH; k++)
                    mat_m[c][k] = (k < n) ? words[pos + c * n + k] : $random(seed);
            pos += NC * n;
            for (int k = 0; k < DEPTH; k++)
                vec_m[k] = (k < n) ? words[pos + k] : $random(seed);
            pos += n;
            if (n >= eff) begin
                for (int c = 0; c < NC; c++)
                    check_data($sformatf("file expected[%0d]", c), words[pos + c],
                               model_result(c, eff));
                pos += NC;
            end
            load_all();
            run_job(len_w, 1'b0, eff);
        end
        if (pos >= FILE_WORDS - 1)
            stop_with_error("vector file has no end marker");
    endtask

    initial begin
        data_t rd;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 27;
        $readmemh("verification/mvm_vectors.txt", words);
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        apb_access(1'b0, REG_RESULT, '0, 1'b1, rd);  // no result before the first run.
        run_file_cases();
        // overwrite one pair of core 5 on top of the last case.
        mat_m[5][0] = 32'h0000_0010;
        mat_m[5][1] = 32'h0000_0020;
        load_pair(5, 0);
        run_job(32'd2, 1'b0, 2);
        apb_access(1'b1, 8'h44, '0, 1'b1, rd);
        run_job(32'd0, 1'b1, DEPTH);
        $display("all tests passed");
        $finish;
    end

endmodule

/* src/mvm_top.sv */
`timescale 1ns/100ps
`include "mvm_macros.svh"

module mvm_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  mvm_data_pkg::data_t   pwdata,
    output mvm_data_pkg::data_t   prdata,
    output logic                  pready,
    output logic                  pslverr
);
    import mvm_data_pkg::*;

    logic [`MVM_NUM_CORES-1:0]    mat_v;
    mat_addr_t                    mat_a;
    logic [2*`MVM_DATA_W-1:0]     mat_d;
    mat_addr_t                    vec_addr;
    data_t                        vec_data;
    logic                         vec_we;
    mat_addr_t                    len;
    logic                         start;
    logic                         busy;
    logic                         done;
    core_idx_t                    res_idx;
    data_t                        res_data;
    logic                         init;
    logic                         exec;
    logic                         update;
    logic                         out_period;
    mat_addr_t                    exec_mat_addr;
    data_t                        exec_src_data;
    data_t                        chain [`MVM_NUM_CORES+1];  // chain[i] is core i's acc.

    mvm_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .mat_v(mat_v), .mat_a(mat_a), .mat_d(mat_d),
        .vec_addr(vec_addr), .vec_data(vec_data), .vec_we(vec_we),
        .len(len), .start(start), .busy(busy), .done(done),
        .res_idx(res_idx), .res_data(res_data)
    );

    mvm_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .vec_addr(vec_addr), .vec_data(vec_data), .vec_we(vec_we),
        .len(len), .start(start), .busy(busy), .done(done),
        .res_idx(res_idx), .res_data(res_data),
        .init(init), .exec(exec), .update(update), .out_period(out_period),
        .exec_mat_addr(exec_mat_addr), .exec_src_data(exec_src_data),
        .chain_acc(chain[0])
    );

    assign chain[`MVM_NUM_CORES] = '0;  // nothing above the last core.

    for (genvar i = 0; i < `MVM_NUM_CORES; i++) begin : g_core
        mvm_core u_core (
            .clk(clk), .rst_n(rst_n),
            .init(init), .mat_v(mat_v[i]), .exec(exec),
            .update(update), .out_period(out_period),
            .mat_a(mat_a), .mat_d(mat_d),
            .exec_mat_addr(exec_mat_addr), .exec_src_data(exec_src_data),
            .acc_next(chain[i+1]), .acc(chain[i])
        );
    end

endmodule

/* src/mvm_sequencer.sv */
`timescale 1ns/100ps
`include "mvm_macros.svh"

module mvm_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mvm_data_pkg::mat_addr_t   vec_addr,
    input  mvm_data_pkg::data_t       vec_data,
    input  logic                      vec_we,
    input  mvm_data_pkg::mat_addr_t   len,
    input  logic                      start,
    output logic                      busy,
    output logic                      done,
    input  mvm_data_pkg::core_idx_t   res_idx,
    output mvm_data_pkg::data_t       res_data,
    output logic                      init,
    output logic                      exec,
    output logic                      update,
    output logic                      out_period,
    output mvm_data_pkg::mat_addr_t   exec_mat_addr,
    output mvm_data_pkg::data_t       exec_src_data,
    input  mvm_data_pkg::data_t       chain_acc
);
    import mvm_data_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_INIT,
        S_STREAM,
        S_DRAIN,
        S_SHIFT,
        S_DONE
    } state_t;

    state_t    state;
    mat_addr_t cnt;
    mat_addr_t last_k;
    data_t     vec_mem [`MVM_MAT_DEPTH];
    data_t     res_buf [`MVM_NUM_CORES];
    data_t     src_q;

    assign last_k = len - 1'b1;     // len 0 wraps to the full depth.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE, S_DONE: begin
                    if (start) begin
                        state <= S_INIT;
                    end
                end
                S_INIT: begin
                    state <= S_STREAM;
                    cnt   <= '0;
                end
                S_STREAM: begin
                    if (cnt == last_k) begin
                        state <= S_DRAIN;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DRAIN: begin
                    if (cnt == mat_addr_t'(2)) begin  // core pipeline is three deep.
                        state <= S_SHIFT;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_SHIFT: begin
                    if (cnt == mat_addr_t'(`MVM_NUM_CORES - 1)) begin
                        state <= S_DONE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign init          = state == S_INIT;
    assign exec          = state == S_STREAM;
    assign out_period    = state == S_SHIFT;
    assign update        = out_period && cnt == '0;  // first shift cycle exposes the accumulators.
    assign exec_mat_addr = cnt;
    assign busy          = state != S_IDLE && state != S_DONE;
    assign done          = state == S_DONE;

    always_ff @(posedge clk) begin
        if (vec_we) begin
            vec_mem[vec_addr] <= vec_data;
        end
    end

    // read on the same edge as the core row read.
    always_ff @(posedge clk) begin
        if (exec) begin
            src_q <= vec_mem[cnt];
        end
    end

    assign exec_src_data = src_q;

    always_ff @(posedge clk) begin
        if (out_period) begin
            res_buf[core_idx_t'(cnt)] <= chain_acc;
        end
    end

    assign res_data = res_buf[res_idx];

endmodule

/* src/mvm_regs.sv */
`timescale 1ns/100ps
`include "mvm_macros.svh"

module mvm_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  mvm_data_pkg::data_t           pwdata,
    output mvm_data_pkg::data_t           prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic [`MVM_NUM_CORES-1:0]     mat_v,
    output mvm_data_pkg::mat_addr_t       mat_a,
    output logic [2*`MVM_DATA_W-1:0]      mat_d,
    output mvm_data_pkg::mat_addr_t       vec_addr,
    output mvm_data_pkg::data_t           vec_data,
    output logic                          vec_we,
    output mvm_data_pkg::mat_addr_t       len,
    output logic                          start,
    input  logic                          busy,
    input  logic                          done,
    output mvm_data_pkg::core_idx_t       res_idx,
    input  mvm_data_pkg::data_t           res_data
);
    import mvm_data_pkg::*;
    import mvm_cfg_pkg::*;

    reg_addr_t offset;
    status_t   status;
    logic      access;
    logic      is_result;
    logic      mapped;
    logic      err;
    logic      wr_ok;
    core_idx_t sel_core;
    mat_addr_t sel_addr;
    mat_addr_t vec_ptr;
    mat_addr_t len_q;
    data_t     mat_lo;

    assign offset    = reg_addr_t'(paddr);
    assign access    = psel && penable;
    assign is_result = (paddr >= REG_RESULT) && (paddr < REG_RESULT_END)
                       && (paddr[1:0] == 2'b00);

    always_comb begin
        case (offset)
            REG_CTRL, REG_STATUS, REG_LEN, REG_MAT_SEL,
            REG_MAT_LO, REG_MAT_HI, REG_VEC_ADDR, REG_VEC_DATA: mapped = 1'b1;
            default: mapped = is_result;
        endcase
    end

    always_comb begin
        err = 1'b0;
        if (!mapped) begin
            err = 1'b1;
        end else if (pwrite && busy && offset != REG_STATUS) begin
            err = 1'b1;                 // no reconfiguration under a running job.
        end else if (!pwrite && is_result && !done) begin
            err = 1'b1;
        end
    end

    assign pready  = 1'b1;
    assign pslverr = access && err;
    assign wr_ok   = access && pwrite && !err;

    // one-cycle strobes straight from the access phase.
    assign mat_v    = (wr_ok && offset == REG_MAT_HI)
                      ? ({{(`MVM_NUM_CORES-1){1'b0}}, 1'b1} << sel_core) : '0;
    assign mat_a    = sel_addr;
    assign mat_d    = {pwdata, mat_lo};
    assign vec_addr = vec_ptr;
    assign vec_data = pwdata;
    assign vec_we   = wr_ok && offset == REG_VEC_DATA;
    assign start    = wr_ok && offset == REG_CTRL && pwdata[0];
    assign len      = len_q;
    assign res_idx  = paddr[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_core <= '0;
            sel_addr <= '0;
            vec_ptr  <= '0;
            len_q    <= '0;
        end else if (wr_ok) begin
            case (offset)
                REG_LEN: len_q <= mat_addr_t'(pwdata);
                REG_MAT_SEL: begin
                    sel_addr <= mat_addr_t'(pwdata);
                    sel_core <= pwdata[10:8];
                end
                REG_VEC_ADDR: vec_ptr <= mat_addr_t'(pwdata);
                REG_VEC_DATA: vec_ptr <= vec_ptr + 1'b1;  // burst fill.
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && offset == REG_MAT_LO) begin
            mat_lo <= pwdata;
        end
    end

    assign status = '{busy: busy, done: done};

    always_comb begin
        prdata = '0;
        if (access && !pwrite && !err) begin
            if (is_result) begin
                prdata = res_data;
            end else begin
                case (offset)
                    REG_STATUS:   prdata = data_t'(status);
                    REG_LEN:      prdata = data_t'(len_q);
                    REG_MAT_SEL:  prdata = {21'd0, sel_core, 1'b0, sel_addr};
                    REG_MAT_LO:   prdata = mat_lo;
                    REG_VEC_ADDR: prdata = data_t'(vec_ptr);
                    default:      prdata = '0;  // strobe-only registers.
                endcase
            end
        end
    end

endmodule

/* src/mvm_core.sv */
`timescale 1ns/100ps
`include "mvm_macros.svh"

module mvm_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      init,
    input  logic                      mat_v,
    input  logic                      exec,
    input  logic                      update,
    input  logic                      out_period,
    input  mvm_data_pkg::mat_addr_t   mat_a,
    input  logic [2*`MVM_DATA_W-1:0]  mat_d,
    input  mvm_data_pkg::mat_addr_t   exec_mat_addr,
    input  mvm_data_pkg::data_t       exec_src_data,
    input  mvm_data_pkg::data_t       acc_next,
    output mvm_data_pkg::data_t       acc
);
    import mvm_data_pkg::*;

    data_t     matrix [`MVM_MAT_DEPTH];
    data_t     row_q;               // row word read at T+1.
    data_t     mat_op;
    data_t     src_op;
    data_t     acc_q;
    data_t     chain_q;
    mat_addr_t hi_addr;
    logic      init_d1;
    logic      init_d2;
    logic      exec_d1;
    logic      exec_d2;

    assign hi_addr = mat_a + 1'b1;  // wraps at the top of the row.

    always_ff @(posedge clk) begin
        if (mat_v) begin
            matrix[mat_a]   <= mat_d[`MVM_DATA_W-1:0];
            matrix[hi_addr] <= mat_d[2*`MVM_DATA_W-1:`MVM_DATA_W];
        end
    end

    always_ff @(posedge clk) begin
        if (exec) begin
            row_q <= matrix[exec_mat_addr];
        end
    end

    // control follows the data through the two register stages.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_d1 <= 1'b0;
            init_d2 <= 1'b0;
            exec_d1 <= 1'b0;
            exec_d2 <= 1'b0;
        end else begin
            init_d1 <= init;
            init_d2 <= init_d1;
            exec_d1 <= exec;
            exec_d2 <= exec_d1;
        end
    end

    // operands get their own stage so the multiplier starts from flops.
    always_ff @(posedge clk) begin
        if (exec_d1) begin
            mat_op <= row_q;
            src_op <= exec_src_data;
        end
    end

    always_ff @(posedge clk) begin
        if (init_d2) begin
            acc_q <= '0;
        end else if (exec_d2) begin
            acc_q <= acc_q + mat_op * src_op;  // low 32 bits only.
        end
    end

    always_ff @(posedge clk) begin
        if (out_period) begin
            chain_q <= acc_next;
        end
    end

    assign acc = update ? acc_q : chain_q;

endmodule

/* src/mvm_cfg_pkg.sv */
`include "mvm_macros.svh"

package mvm_cfg_pkg;

    // APB register offsets.
    typedef enum logic [7:0] {
        REG_CTRL     = 8'h00,   // bit 0 starts a run.
        REG_STATUS   = 8'h04,
        REG_LEN      = 8'h08,   // 0 means the full depth.
        REG_MAT_SEL  = 8'h0C,   // row address in [6:0], core in [10:8].
        REG_MAT_LO   = 8'h10,
        REG_MAT_HI   = 8'h14,   // writing this one commits the pair.
        REG_VEC_ADDR = 8'h18,
        REG_VEC_DATA = 8'h1C,
        REG_RESULT   = 8'h20    // first of the result words.
    } reg_addr_t;

    // one past the last result word.
    localparam logic [7:0] REG_RESULT_END = 8'(REG_RESULT + 4 * `MVM_NUM_CORES);

    typedef struct packed {
        logic busy;
        logic done;
    } status_t;

endpackage

/* src/mvm_data_pkg.sv */
`include "mvm_macros.svh"

package mvm_data_pkg;

    // one matrix, vector or accumulator word.
    typedef logic [`MVM_DATA_W-1:0] data_t;

    // row index into a core memory or the vector memory.
    typedef logic [$clog2(`MVM_MAT_DEPTH)-1:0] mat_addr_t;

    // selects one of the cores.
    typedef logic [$clog2(`MVM_NUM_CORES)-1:0] core_idx_t;

endpackage

/* src/mvm_macros.svh */
`ifndef MVM_MACROS_SVH
`define MVM_MACROS_SVH

// array geometry shared by the whole accelerator.

`define MVM_NUM_CORES 8     // one core per matrix row.

`define MVM_MAT_DEPTH 128   // words per row and entries in the vector memory.

`define MVM_DATA_W    32    // matrix, vector and accumulator word width.

`endif
